//--- src/ddr3_wr_cfg.svh
`ifndef DDR3_WR_CFG_SVH
`define DDR3_WR_CFG_SVH

// record word layout, tag sits above the payload
`define DDR3_TAG_W 4
`define DDR3_PAYLOAD_W 128

// memory burst address and the zero bits below it in the byte address
`define DDR3_BADDR_W 23
`define DDR3_ADDR_SHIFT 3

// width of the burst and address counters
`define DDR3_CNT_W 24

// record tag codes
`define TAG_FILL_HDR 4'd1
`define TAG_WFM_HDR 4'd2
`define TAG_CKSM 4'd4

// fields inside a waveform header
`define WFM_ADDR_LSB 29
`define WFM_ADDR_MSB 51
`define WFM_BURSTS_MSB 10

// data-ahead counter of the address throttle
`define THROTTLE_W 5

`endif

//--- src/ddr3_wr_pkg.sv
`default_nettype none

`include "ddr3_wr_cfg.svh"

package ddr3_wr_pkg;

    // plain vectors for the widths of the record format
    typedef logic [`DDR3_TAG_W-1:0] tag_t;
    typedef logic [`DDR3_PAYLOAD_W-1:0] payload_t;
    typedef logic [`DDR3_TAG_W+`DDR3_PAYLOAD_W-1:0] fifo_word_t;
    typedef logic [`DDR3_BADDR_W-1:0] burst_addr_t;
    typedef logic [`DDR3_BADDR_W+`DDR3_ADDR_SHIFT-1:0] mem_addr_t;
    typedef logic [`DDR3_CNT_W-1:0] cnt_t;

    // fill-header FIFO entry, total burst count over the header payload
    typedef logic [`DDR3_CNT_W+`DDR3_PAYLOAD_W-1:0] fill_hdr_t;

    // record-level write states
    typedef enum logic [3:0] {
        IDLE, TST_TAG, SYNC_ERR,
        INIT_FILL, WRITE_FILL,
        INIT_WFM, WRITE_WFM,
        INIT_CKSM, WRITE_CKSM,
        WRITE_HDR, DONE
    } wr_state_t;

endpackage

`default_nettype wire

//--- src/wr_record_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_wr_cfg.svh"

module wr_record_fsm (
    input  logic                clk,
    input  logic                reset,
    input  logic                fifo_empty,
    input  ddr3_wr_pkg::tag_t   head_tag,
    input  logic                addr_left_zero,
    input  logic                burst_left_zero,
    input  logic                acq_done,
    output logic                load_fill,
    output logic                load_wfm,
    output logic                load_cksm,
    output logic                write_active,
    output logic                fill_hdr_wr_en,
    output logic                sync_err,
    output logic                wr_done
);

    import ddr3_wr_pkg::*;

    wr_state_t state;
    wr_state_t next_state;

    // acq_done comes from the acquisition clock domain
    logic acq_done_meta;
    logic acq_done_sync;

    // a write state is finished once every burst and every address went out
    logic seg_done;

    assign seg_done = addr_left_zero && burst_left_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_meta <= 1'b0;
            acq_done_sync <= 1'b0;
        end else begin
            acq_done_meta <= acq_done;
            acq_done_sync <= acq_done_meta;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // first-word fall-through, a non-empty FIFO has a valid head
            IDLE: begin
                if (!fifo_empty) begin
                    next_state = TST_TAG;
                end
            end
            // the head word has to start a record
            TST_TAG: begin
                case (head_tag)
                    `TAG_FILL_HDR: next_state = INIT_FILL;
                    `TAG_WFM_HDR:  next_state = INIT_WFM;
                    `TAG_CKSM:     next_state = INIT_CKSM;
                    default:       next_state = SYNC_ERR;
                endcase
            end
            // lost sync, only reset gets out of here
            SYNC_ERR:  next_state = SYNC_ERR;
            INIT_FILL: next_state = WRITE_FILL;
            INIT_WFM:  next_state = WRITE_WFM;
            INIT_CKSM: next_state = WRITE_CKSM;
            WRITE_FILL: begin
                if (seg_done) begin
                    next_state = IDLE;
                end
            end
            WRITE_WFM: begin
                if (seg_done) begin
                    next_state = IDLE;
                end
            end
            // checksum closes the fill, header entry follows
            WRITE_CKSM: begin
                if (seg_done) begin
                    next_state = WRITE_HDR;
                end
            end
            WRITE_HDR: next_state = DONE;
            // hold off the next fill until acquisition has finished
            DONE: begin
                if (acq_done_sync) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // outputs are registered from the next state so they line up with it
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= IDLE;
            load_fill      <= 1'b0;
            load_wfm       <= 1'b0;
            load_cksm      <= 1'b0;
            write_active   <= 1'b0;
            fill_hdr_wr_en <= 1'b0;
            sync_err       <= 1'b0;
            wr_done        <= 1'b0;
        end else begin
            state          <= next_state;
            load_fill      <= (next_state == INIT_FILL);
            load_wfm       <= (next_state == INIT_WFM);
            load_cksm      <= (next_state == INIT_CKSM);
            write_active   <= (next_state == WRITE_FILL) || (next_state == WRITE_WFM) ||
                              (next_state == WRITE_CKSM);
            fill_hdr_wr_en <= (next_state == WRITE_HDR);
            sync_err       <= (next_state == SYNC_ERR);
            wr_done        <= (next_state == DONE);
        end
    end

    // at most one counter load per cycle
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({load_fill, load_wfm, load_cksm}));

    // sync error is sticky until reset
    assert property (@(posedge clk) sync_err && !reset |=> sync_err);

endmodule

`default_nettype wire

//--- src/burst_counters.sv
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_wr_cfg.svh"

module burst_counters (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_fill,
    input  logic                load_wfm,
    input  logic                load_cksm,
    input  ddr3_wr_pkg::cnt_t   head_bursts,
    input  logic                addr_accept,
    input  logic                data_accept,
    output logic                addr_left_zero,
    output logic                burst_left_zero,
    output logic                addr_allow,
    output ddr3_wr_pkg::cnt_t   total_bursts
);

    import ddr3_wr_pkg::*;

    // addresses and bursts still owed for the current record
    cnt_t addr_left;
    cnt_t burst_left;

    // accepted data bursts still waiting for their address
    logic [`THROTTLE_W-1:0] data_ahead;

    // fill header and checksum are single bursts
    logic load_single;

    // waveform header burst plus its data bursts
    cnt_t wfm_bursts;

    assign load_single = load_fill || load_cksm;
    assign wfm_bursts  = head_bursts + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_left <= '0;
        end else if (load_single) begin
            addr_left <= cnt_t'(1);
        end else if (load_wfm) begin
            addr_left <= wfm_bursts;
        end else if (addr_accept) begin
            addr_left <= addr_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            burst_left <= '0;
        end else if (load_single) begin
            burst_left <= cnt_t'(1);
        end else if (load_wfm) begin
            burst_left <= wfm_bursts;
        end else if (data_accept) begin
            burst_left <= burst_left - 1'b1;
        end
    end

    assign addr_left_zero  = (addr_left == '0);
    assign burst_left_zero = (burst_left == '0);

    // every accepted address of the fill counts, headers and checksum included
    always_ff @(posedge clk) begin
        if (reset) begin
            total_bursts <= '0;
        end else if (load_fill) begin
            total_bursts <= '0;
        end else if (addr_accept) begin
            total_bursts <= total_bursts + 1'b1;
        end
    end

    // data accepts minus address accepts, unchanged when both happen together
    always_ff @(posedge clk) begin
        if (reset) begin
            data_ahead <= '0;
        end else if (data_accept && !addr_accept) begin
            data_ahead <= data_ahead + 1'b1;
        end else if (addr_accept && !data_accept) begin
            data_ahead <= data_ahead - 1'b1;
        end
    end

    // an address may only be offered once its data is in
    assign addr_allow = (data_ahead != '0);

    assert property (@(posedge clk) disable iff (reset) addr_accept |-> !addr_left_zero);

    assert property (@(posedge clk) disable iff (reset) data_accept |-> !burst_left_zero);

    // an address accept without data needs earlier data waiting
    assert property (@(posedge clk) disable iff (reset)
        addr_accept && !data_accept |-> data_ahead != '0);

endmodule

`default_nettype wire

//--- src/record_datapath.sv
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_wr_cfg.svh"

module record_datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  ddr3_wr_pkg::fifo_word_t fifo_dat,
    input  logic                    fifo_empty,
    input  logic                    load_fill,
    input  logic                    load_wfm,
    input  logic                    write_active,
    input  logic                    addr_left_zero,
    input  logic                    burst_left_zero,
    input  logic                    addr_allow,
    input  ddr3_wr_pkg::cnt_t       total_bursts,
    input  logic                    app_wdf_rdy,
    input  logic                    wr_app_rdy,
    output logic                    app_wdf_wren,
    output logic                    wr_app_en,
    output logic                    fifo_rd_en,
    output logic                    addr_accept,
    output logic                    data_accept,
    output ddr3_wr_pkg::mem_addr_t  wr_addr,
    output ddr3_wr_pkg::fill_hdr_t  fill_hdr_dat
);

    import ddr3_wr_pkg::*;

    burst_addr_t addr_gen;
    payload_t    hdr_payload;
    cnt_t        hdr_count;

    // high through a fill or waveform segment, low in a checksum segment
    logic hdr_seg;

    // last write cycle of a segment, all bursts and addresses accepted
    logic seg_done;

    assign seg_done = write_active && addr_left_zero && burst_left_zero;

    // fill starts at zero, waveform at its header address, checksum runs on
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
        end else if (load_fill) begin
            addr_gen <= '0;
        end else if (load_wfm) begin
            addr_gen <= fifo_dat[`WFM_ADDR_MSB:`WFM_ADDR_LSB];
        end else if (addr_accept) begin
            addr_gen <= addr_gen + 1'b1;
        end
    end

    assign wr_addr = {addr_gen, {`DDR3_ADDR_SHIFT{1'b0}}};

    // checksum load never reaches here, so it is the segment without a header load
    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_seg <= 1'b0;
        end else if (load_fill || load_wfm) begin
            hdr_seg <= 1'b1;
        end else if (seg_done) begin
            hdr_seg <= 1'b0;
        end
    end

    // header payload without its tag, taken while it is still the FIFO head
    always_ff @(posedge clk) begin
        if (load_fill) begin
            hdr_payload <= fifo_dat[`DDR3_PAYLOAD_W-1:0];
        end
    end

    // total is final once the checksum address has gone out
    always_ff @(posedge clk) begin
        if (seg_done && !hdr_seg) begin
            hdr_count <= total_bursts;
        end
    end

    assign fill_hdr_dat = {hdr_count, hdr_payload};

    // data request needs a head word and bursts left in the segment
    assign app_wdf_wren = write_active && !fifo_empty && !burst_left_zero;

    // address request waits for its data to be accepted first
    assign wr_app_en = write_active && addr_allow && !addr_left_zero;

    assign data_accept = app_wdf_wren && app_wdf_rdy;
    assign addr_accept = wr_app_en && wr_app_rdy;

    // memory took the head word, bring up the next one
    assign fifo_rd_en = data_accept;

    assert property (@(posedge clk) disable iff (reset) wr_app_en |-> addr_allow);

    // a stalled address request keeps its address until the memory takes it
    assert property (@(posedge clk) disable iff (reset)
        wr_app_en && !wr_app_rdy |=> wr_app_en && $stable(wr_addr));

endmodule

`default_nettype wire

//--- src/ddr3_wr_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_wr_cfg.svh"

module ddr3_wr_control (
    input  logic                    clk,
    input  logic                    reset,
    input  ddr3_wr_pkg::fifo_word_t fifo_dat,
    input  logic                    fifo_empty,
    output logic                    fifo_rd_en,
    output logic                    app_wdf_wren,
    input  logic                    app_wdf_rdy,
    output ddr3_wr_pkg::mem_addr_t  wr_addr,
    output logic                    wr_app_en,
    input  logic                    wr_app_rdy,
    output ddr3_wr_pkg::fill_hdr_t  fill_hdr_dat,
    output logic                    fill_hdr_wr_en,
    output logic                    sync_err,
    output logic                    wr_done,
    input  logic                    acq_done
);

    import ddr3_wr_pkg::*;

    // fields of the FIFO head word
    tag_t head_tag;
    cnt_t head_bursts;

    // strobes and level from the state machine
    logic load_fill;
    logic load_wfm;
    logic load_cksm;
    logic write_active;

    // counter status
    logic addr_left_zero;
    logic burst_left_zero;
    logic addr_allow;
    cnt_t total_bursts;

    // handshake events
    logic addr_accept;
    logic data_accept;

    assign head_tag = fifo_dat[`DDR3_TAG_W+`DDR3_PAYLOAD_W-1:`DDR3_PAYLOAD_W];

    // burst count of a waveform header, zero extended to counter width
    assign head_bursts = cnt_t'(fifo_dat[`WFM_BURSTS_MSB:0]);

    wr_record_fsm i_wr_record_fsm (
        .clk(clk), .reset(reset),
        .fifo_empty(fifo_empty), .head_tag(head_tag),
        .addr_left_zero(addr_left_zero), .burst_left_zero(burst_left_zero),
        .acq_done(acq_done),
        .load_fill(load_fill), .load_wfm(load_wfm), .load_cksm(load_cksm),
        .write_active(write_active), .fill_hdr_wr_en(fill_hdr_wr_en),
        .sync_err(sync_err), .wr_done(wr_done)
    );

    burst_counters i_burst_counters (
        .clk(clk), .reset(reset),
        .load_fill(load_fill), .load_wfm(load_wfm), .load_cksm(load_cksm),
        .head_bursts(head_bursts),
        .addr_accept(addr_accept), .data_accept(data_accept),
        .addr_left_zero(addr_left_zero), .burst_left_zero(burst_left_zero),
        .addr_allow(addr_allow), .total_bursts(total_bursts)
    );

    record_datapath i_record_datapath (
        .clk(clk), .reset(reset),
        .fifo_dat(fifo_dat), .fifo_empty(fifo_empty),
        .load_fill(load_fill), .load_wfm(load_wfm), .write_active(write_active),
        .addr_left_zero(addr_left_zero), .burst_left_zero(burst_left_zero),
        .addr_allow(addr_allow), .total_bursts(total_bursts),
        .app_wdf_rdy(app_wdf_rdy), .wr_app_rdy(wr_app_rdy),
        .app_wdf_wren(app_wdf_wren), .wr_app_en(wr_app_en), .fifo_rd_en(fifo_rd_en),
        .addr_accept(addr_accept), .data_accept(data_accept),
        .wr_addr(wr_addr), .fill_hdr_dat(fill_hdr_dat)
    );

endmodule

`default_nettype wire

//--- tests/tb_ddr3_wr_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_wr_cfg.svh"

module tb_ddr3_wr_control;

    import ddr3_wr_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic        acq_done;
    fifo_word_t  fifo_dat = '0;
    logic        fifo_empty = 1'b1;
    logic        app_wdf_rdy = 1'b0;
    logic        wr_app_rdy = 1'b0;
    logic        fifo_rd_en;
    logic        app_wdf_wren;
    mem_addr_t   wr_addr;
    logic        wr_app_en;
    fill_hdr_t   fill_hdr_dat;
    logic        fill_hdr_wr_en;
    logic        sync_err;
    logic        wr_done;

    // FIFO model contents and what the memory model saw
    fifo_word_t  fifo_q[$];
    payload_t    data_log[$];
    mem_addr_t   addr_log[$];
    int          data_cyc[$];
    int          addr_cyc[$];
    fill_hdr_t   hdr_log;
    int          hdr_pulses = 0;
    int          edge_count = 0;
    logic        pop_pending = 1'b0;
    logic [31:0] rng = 32'h6a2b;

    // current test from the trace
    string       trace_lines[$];
    string       test_name;
    fifo_word_t  words[$];
    mem_addr_t   exp_addrs[$];
    fill_hdr_t   hdr_exp;
    logic        hdr_expected;
    logic        exp_err;
    logic        exp_done;

    int          total_words = 0;
    int          cycle_limit = 2000;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;

    ddr3_wr_control i_ddr3_wr_control (
        .clk(clk), .reset(reset),
        .fifo_dat(fifo_dat), .fifo_empty(fifo_empty), .fifo_rd_en(fifo_rd_en),
        .app_wdf_wren(app_wdf_wren), .app_wdf_rdy(app_wdf_rdy),
        .wr_addr(wr_addr), .wr_app_en(wr_app_en), .wr_app_rdy(wr_app_rdy),
        .fill_hdr_dat(fill_hdr_dat), .fill_hdr_wr_en(fill_hdr_wr_en),
        .sync_err(sync_err), .wr_done(wr_done), .acq_done(acq_done)
    );

    // 4 ns period
    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(input string what, input logic [151:0] expected,
                                 input logic [151:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // accepts happen at the rising edge where both handshake lines are high
    always @(posedge clk) begin
        pop_pending = fifo_rd_en && !reset;
        if (!reset && app_wdf_wren && app_wdf_rdy) begin
            // memory takes the payload straight off the FIFO head
            data_log.push_back(fifo_dat[`DDR3_PAYLOAD_W-1:0]);
            data_cyc.push_back(edge_count);
        end
        if (!reset && wr_app_en && wr_app_rdy) begin
            addr_log.push_back(wr_addr);
            addr_cyc.push_back(edge_count);
        end
        if (!reset && fill_hdr_wr_en) begin
            hdr_pulses++;
            hdr_log = fill_hdr_dat;
        end
        // the FIFO read goes with the data accept, in the same cycle
        if (!reset) begin
            compare_value("fifo_rd_en", app_wdf_wren && app_wdf_rdy, fifo_rd_en);
        end
        edge_count++;
    end

    // FIFO drops the word the memory took, ready lines stall at random
    always @(negedge clk) begin
        if (pop_pending && fifo_q.size() > 0) begin
            void'(fifo_q.pop_front());
        end
        fifo_empty = (fifo_q.size() == 0);
        fifo_dat = fifo_empty ? '0 : fifo_q[0];
        rng = xorshift32(rng);
        app_wdf_rdy = (rng[1:0] != 2'b00);
        // address side stalls more often so data piles up ahead
        wr_app_rdy = (rng[4:3] == 2'b11) || rng[7];
    end

    initial begin
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    task automatic run_test();
        int quiet_accepts;
        fifo_word_t word;
        @(negedge clk);
        reset = 1'b1;
        acq_done = 1'b0;
        // load the FIFO while the DUT sits in reset
        @(posedge clk);
        fifo_q = words;
        data_log.delete();
        data_cyc.delete();
        addr_log.delete();
        addr_cyc.delete();
        hdr_pulses = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        // a fill ends in wr_done, a bad tag in sync_err
        while (!wr_done && !sync_err) begin
            @(negedge clk);
        end
        compare_value("sync_err", exp_err, sync_err);
        compare_value("wr_done", exp_done, wr_done);
        if (sync_err) begin
            quiet_accepts = data_log.size() + addr_log.size();
            repeat (16) @(negedge clk);
            compare_value("accepts after sync loss", quiet_accepts,
                          data_log.size() + addr_log.size());
        end else begin
            repeat (4) begin
                @(negedge clk);
                compare_value("wr_done before acq_done", 1'b1, wr_done);
            end
            acq_done = 1'b1;
            while (wr_done) begin
                @(negedge clk);
            end
            acq_done = 1'b0;
        end
        compare_value("address count", exp_addrs.size(), addr_log.size());
        compare_value("data count", exp_addrs.size(), data_log.size());
        // k-th address pairs with the k-th data word
        foreach (exp_addrs[k]) begin
            if (k < addr_log.size() && k < data_log.size()) begin
                word = words[k];
                compare_value($sformatf("address %0d", k), exp_addrs[k], addr_log[k]);
                compare_value($sformatf("data %0d", k), word[`DDR3_PAYLOAD_W-1:0], data_log[k]);
                if (addr_cyc[k] < data_cyc[k]) begin
                    errors++;
                    $display("%s: address %0d was accepted before its data", test_name, k);
                end
            end
        end
        compare_value("fill header pulses", hdr_expected, hdr_pulses);
        if (hdr_expected && hdr_pulses == 1) begin
            compare_value("fill header word", hdr_exp, hdr_log);
        end
    endtask

    initial begin
        int fd;
        int tests_run;
        string line;
        logic [7:0] key;
        logic [151:0] v1;
        logic [151:0] v2;
        reset = 1'b1;
        acq_done = 1'b0;
        tests_run = 0;
        fd = $fopen("tests/ddr3_wr_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file tests/ddr3_wr_trace.txt");
        end else begin
            // keep every line except blanks and comments
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 2 && line.getc(0) != "#") begin
                    trace_lines.push_back(line);
                    if (line.getc(0) == "W") begin
                        total_words++;
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * total_words + 2000;
        foreach (trace_lines[i]) begin
            line = trace_lines[i];
            key = line.getc(0);
            // value columns, meaningless on name lines
            void'($sscanf(line.substr(2, line.len() - 1), "%h %h", v1, v2));
            case (key)
                "T": begin
                    test_name = line.substr(2, line.len() - 2);
                    words.delete();
                    exp_addrs.delete();
                    hdr_expected = 1'b0;
                end
                "W": words.push_back(fifo_word_t'(v1));
                "A": exp_addrs.push_back(mem_addr_t'(v1));
                "H": begin
                    hdr_exp = v1;
                    hdr_expected = 1'b1;
                end
                "E": begin
                    exp_err = v1[0];
                    exp_done = v2[0];
                    run_test();
                    tests_run++;
                end
                default: begin
                    errors++;
                    $display("unknown line in the trace file: %s", line);
                end
            endcase
        end
        if (tests_run == 0) begin
            errors++;
            $display("the trace file holds no tests");
        end
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ddr3_wr_trace.txt
# T test name | W FIFO word, tag over payload | A expected byte address, in order
# H expected fill-header entry, count over payload | E expected sync_err and wr_done

T fill_cksm
W 10123456789abcdef0011223344556677
W 45a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
A 0000000
A 0000008
H 0000020123456789abcdef0011223344556677
E 0 1

T fill_wfm_cksm
W 111112222333344445555666677778888
W 2ab000000000000000000002000001003
W 0a1a1a1a1a1a1a1a1a1a1a1a1a1a1a1a1
W 0b2b2b2b2b2b2b2b2b2b2b2b2b2b2b2b2
W 0c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3
W 4e7e7e7e7e7e7e7e7e7e7e7e7e7e7e7e7
A 0000000
A 0000800
A 0000808
A 0000810
A 0000818
A 0000820
H 00000611112222333344445555666677778888
E 0 1

T two_waveforms
W 1cafe0000cafe0000cafe0000cafe0001
W 200000000000000000000000800000001
W 0d4d4d4d4d4d4d4d4d4d4d4d4d4d4d4d4
W 20000000000000000000fffffc0000000
W 46b6b6b6b6b6b6b6b6b6b6b6b6b6b6b6b
A 0000000
A 0000200
A 0000208
A 3fffff0
A 3fffff8
H 000005cafe0000cafe0000cafe0000cafe0001
E 0 1

T sync_loss
W 133333333333333333333333333333333
W 300000000000000000000000000000000
W 477777777777777777777777777777777
A 0000000
E 1 0

//--- compile.f
+incdir+src
src/ddr3_wr_pkg.sv
src/wr_record_fsm.sv
src/burst_counters.sv
src/record_datapath.sv
src/ddr3_wr_control.sv
tests/tb_ddr3_wr_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the DDR3 write controller testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ddr3_wr_control \
    --Mdir obj_dir \
    -f compile.f

sim_out=$(./obj_dir/Vtb_ddr3_wr_control)
echo "$sim_out"

# verdict is a line of its own in the simulation output
if ! grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 1
fi
